/* Makefile */
TOP := tb_minimig_glue

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f minimig_glue.f --top-module minimig_glue

sim:
	verilator --binary --timing --assert -f minimig_glue.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* minimig_glue.f */
+incdir+verilog
+incdir+tb
verilog/minimig_glue_pkg.sv
verilog/cfg_regs.sv
verilog/reset_seq.sv
verilog/irq_encoder.sv
verilog/board_status.sv
verilog/minimig_glue.sv
tb/tb_minimig_glue.sv

/* tb/tb_axil_tasks.svh */
// axi4-lite host tasks
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);                // one step per bit
		v      = {v[30:0], lfsr_q[31]};
	end
endtask

// -------------------------------------------------------------------------
// all tasks start and end 1 ns after a rising edge
task automatic send_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
	int   n;
	logic taken;
	n     = 0;
	taken = 1'b0;
	s_axi_req_i.awaddr  = addr;
	s_axi_req_i.wdata   = data;
	s_axi_req_i.wstrb   = strb;
	s_axi_req_i.awvalid = 1'b1;
	s_axi_req_i.wvalid  = 1'b1;
	while (!taken) begin
		@(negedge clk);
		taken = s_axi_rsp_o.awready & s_axi_rsp_o.wready;   // taken at next edge
		@(posedge clk);
		#1;
		n++;
		if (!taken && n > WAIT_MAX)
			fail_run("timeout, write address and data were never accepted");
	end
	s_axi_req_i.awvalid = 1'b0;
	s_axi_req_i.wvalid  = 1'b0;
endtask

task automatic take_bresp(output axil_resp_e resp);
	int   n;
	logic seen;
	n    = 0;
	seen = 1'b0;
	s_axi_req_i.bready = 1'b1;
	while (!seen) begin
		@(negedge clk);
		seen = s_axi_rsp_o.bvalid;
		resp = s_axi_rsp_o.bresp;
		@(posedge clk);
		#1;
		n++;
		if (!seen && n > WAIT_MAX)
			fail_run("timeout, no write response");
	end
	s_axi_req_i.bready = 1'b0;
endtask

task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axil_resp_e resp);
	send_write(addr, data, strb);
	take_bresp(resp);
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
		output axil_resp_e resp);
	int   n;
	logic done;
	n    = 0;
	done = 1'b0;
	s_axi_req_i.araddr  = addr;
	s_axi_req_i.arvalid = 1'b1;
	while (!done) begin
		@(negedge clk);
		done = s_axi_rsp_o.arready;
		@(posedge clk);
		#1;
		n++;
		if (!done && n > WAIT_MAX)
			fail_run("timeout, read address was never accepted");
	end
	s_axi_req_i.arvalid = 1'b0;
	s_axi_req_i.rready  = 1'b1;
	done = 1'b0;
	while (!done) begin
		@(negedge clk);
		done = s_axi_rsp_o.rvalid;
		data = s_axi_rsp_o.rdata;
		resp = s_axi_rsp_o.rresp;
		@(posedge clk);
		#1;
		n++;
		if (!done && n > 2 * WAIT_MAX)
			fail_run("timeout, no read data");
	end
	s_axi_req_i.rready = 1'b0;
endtask

`endif

/* tb/tb_minimig_glue.sv */
// minimig glue testbench
`default_nettype none
`include "minimig_glue_cfg.svh"

module tb_minimig_glue import minimig_glue_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_MAX = 64;     // cycles per handshake

	logic        clk;
	logic        reset;
	axil_req_t   s_axi_req_i;
	axil_rsp_t   s_axi_rsp_o;
	logic        kbdrst_i;
	logic        cpu_reset_n_i;
	logic        sof_i;
	logic        int7_i;
	logic [5:0]  irq_i;
	logic        ovl_i;
	logic        cpu_custom_i;
	logic        led_n_i;
	logic        hsync_n_i;
	logic        vsync_n_i;
	logic        rst_o;
	logic        cpu_reset_n_o;
	logic [2:0]  ipl_n_o;
	logic        ntsc_o;
	logic [5:0]  memcfg_o;
	logic [3:0]  cpu_config_o;
	logic        turbochipram_o;
	logic        turbokick_o;
	logic        pwr_led_o;
	logic        vsync_toggle_o;

	logic [31:0] lfsr_q;
	logic [31:0] exp_reg [5];        // memory, chipset, floppy, ide, cpu
	logic        ntsc_exp;
	logic [2:0]  ipl_exp;            // ipl_n_o after the next edge
	logic        ipl_armed;
	logic        vs_prev;
	logic        vt_prev;
	int          vs_pend;            // falls not yet answered by a flip
	int          vs_age;
	int          vs_flips;

	minimig_glue DUT (.*);

	always #2 clk = ~clk;

	// -------------------------------------------------------------------------
	task automatic stop_failed();
		$display("CHECKS FAILED");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		stop_failed();
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_failed();
		end
	endtask

	`include "tb_axil_tasks.svh"

	// level 7 first, then irq bits from the top down
	function automatic logic [2:0] top_level(input logic i7, input logic [5:0] irq);
		top_level = 3'd0;
		if (i7)
			top_level = 3'd7;
		else
			for (int k = 5; k >= 0; k--)
				if (irq[k] && top_level == 3'd0)
					top_level = 3'(k + 1);
	endfunction

	function automatic logic [31:0] reg_mask(input int idx);
		case (idx)
			0:       reg_mask = 32'h7f;
			1:       reg_mask = 32'h1f;
			3:       reg_mask = 32'h07;
			default: reg_mask = 32'h0f;      // floppy and cpu
		endcase
	endfunction

	task automatic write_reg(input int idx, input logic [31:0] val, input logic [3:0] strb);
		axil_resp_e resp;
		axil_write(8'(idx * 4), val, strb, resp);
		check_eq("bresp", 32'(resp), 32'(RESP_OKAY));
		if (strb[0])
			exp_reg[idx] = val & reg_mask(idx);   // lane 0 clear leaves it alone
	endtask

	task automatic check_regs();
		logic [31:0] rd;
		axil_resp_e  resp;
		for (int i = 0; i < 5; i++) begin
			axil_read(8'(i * 4), rd, resp);
			check_eq("rresp", 32'(resp), 32'(RESP_OKAY));
			check_eq("rdata", rd, exp_reg[i]);
		end
	endtask

	// sources already released, reset must last exactly this many sof pulses
	task automatic release_after_frames(input int frames);
		for (int i = 1; i <= frames; i++) begin
			repeat (2) begin
				@(negedge clk);
				check_eq("rst_o", 32'(rst_o), 32'd1);
				check_eq("cpu_reset_n_o", 32'(cpu_reset_n_o), 32'd0);
				@(posedge clk);
				#1;
			end
			sof_i = 1'b1;
			@(posedge clk);
			#1;
			sof_i = 1'b0;
			@(negedge clk);
			check_eq("rst_o", 32'(rst_o), 32'(i < frames));
			check_eq("cpu_reset_n_o", 32'(cpu_reset_n_o), 32'(i == frames));
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_derived();
		logic aga;
		aga = exp_reg[1][4];
		check_eq("memcfg_o", 32'(memcfg_o), exp_reg[0] & 32'h3f);
		check_eq("cpu_config_o", 32'(cpu_config_o), exp_reg[4]);
		check_eq("turbochipram_o", 32'(turbochipram_o), 32'(aga & ~ovl_i & exp_reg[4][2] &
			cpu_custom_i & exp_reg[0][1] & exp_reg[0][0]));
		check_eq("turbokick_o", 32'(turbokick_o), 32'(~ovl_i & exp_reg[4][3] & aga));
		check_eq("ntsc_o", 32'(ntsc_o), 32'(ntsc_exp));
	endtask

	// -------------------------------------------------------------------------
	// checkers
	assert property (@(posedge clk) disable iff (reset) !led_n_i |-> pwr_led_o)
		else check_eq("pwr_led_o", 32'($sampled(pwr_led_o)), 32'd1);
	assert property (@(posedge clk) disable iff (reset) !cpu_reset_n_i |-> rst_o)
		else check_eq("rst_o", 32'($sampled(rst_o)), 32'd1);
	assert property (@(posedge clk) disable iff (reset) (rst_o && cpu_reset_n_i) |-> !cpu_reset_n_o)
		else check_eq("cpu_reset_n_o", 32'($sampled(cpu_reset_n_o)), 32'd0);

	always @(negedge clk) begin
		if (ipl_armed)
			check_eq("ipl_n_o", 32'(ipl_n_o), 32'(ipl_exp));
		ipl_exp   = (reset || rst_o) ? 3'b111 : ~top_level(int7_i, irq_i);
		ipl_armed = 1'b1;
	end

	always @(negedge clk) begin
		if (reset) begin
			vs_prev = 1'b1;
			vt_prev = 1'b0;
			vs_pend = 0;
			vs_age  = 0;
		end else begin
			if (vsync_toggle_o !== vt_prev) begin
				assert (vs_pend != 0) else check_eq("vsync_toggle_o", 32'(vsync_toggle_o), 32'(vt_prev));
				vs_pend--;
				vs_flips++;
			end
			if (vs_pend != 0) begin
				vs_age++;
				if (vs_age > 2)
					fail_run("vsync_toggle_o did not flip within 2 cycles of a vsync falling edge");
			end
			if (vs_prev && !vsync_n_i) begin          // falling edge seen
				vs_pend++;
				vs_age = 0;
			end
			vs_prev = vsync_n_i;
			vt_prev = vsync_toggle_o;
		end
	end

	// -------------------------------------------------------------------------
	initial begin
		logic [31:0] v;
		logic [31:0] rd;
		axil_resp_e  resp;
		int          lit;
		lfsr_q        = 32'h4a3cf879;
		clk           = 1'b0;
		reset         = 1'b1;
		s_axi_req_i   = '0;
		kbdrst_i      = 1'b0;
		cpu_reset_n_i = 1'b1;
		sof_i         = 1'b0;
		int7_i        = 1'b0;
		irq_i         = '0;
		ovl_i         = 1'b0;
		cpu_custom_i  = 1'b0;
		led_n_i       = 1'b1;
		hsync_n_i     = 1'b1;
		vsync_n_i     = 1'b1;
		ipl_armed     = 1'b0;
		ntsc_exp      = 1'b0;
		vs_flips      = 0;
		for (int i = 0; i < 5; i++)
			exp_reg[i] = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// reset release, random interrupts must stay masked
		for (int i = 0; i < 6; i++) begin
			rand_bits(7, v);
			irq_i  = v[5:0];
			int7_i = v[6];
			@(negedge clk);
			check_eq("rst_o", 32'(rst_o), 32'd1);
			check_eq("ipl_n_o", 32'(ipl_n_o), 32'h7);
			check_eq("vsync_toggle_o", 32'(vsync_toggle_o), 32'd0);
			check_eq("bvalid", 32'(s_axi_rsp_o.bvalid), 32'd0);
			check_eq("rvalid", 32'(s_axi_rsp_o.rvalid), 32'd0);
			@(posedge clk);
			#1;
		end
		release_after_frames(`MG_RESET_FRAMES);

		// register access, masking and strobe
		for (int r = 0; r < 5; r++) begin
			repeat (3) begin
				rand_bits(32, v);
				write_reg(r, v, 4'hf);
				check_regs();
			end
			rand_bits(32, v);
			write_reg(r, v, 4'he);
		end
		check_regs();
		axil_write(8'h1c, 32'hffffffff, 4'hf, resp);   // hole in the map
		check_eq("bresp", 32'(resp), 32'(RESP_SLVERR));
		axil_read(8'h80, rd, resp);
		check_eq("rresp", 32'(resp), 32'(RESP_SLVERR));
		check_eq("rdata", rd, 32'h0);

		// bready held low blocks the next write
		send_write(`MG_REG_FLOPPY, 32'h5, 4'h1);
		exp_reg[2] = 32'h5;
		s_axi_req_i.awaddr  = `MG_REG_IDE;
		s_axi_req_i.wdata   = 32'h6;
		s_axi_req_i.awvalid = 1'b1;
		s_axi_req_i.wvalid  = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_eq("bvalid", 32'(s_axi_rsp_o.bvalid), 32'd1);
			check_eq("awready", 32'(s_axi_rsp_o.awready), 32'd0);
			@(posedge clk);
			#1;
		end
		take_bresp(resp);
		check_eq("bresp", 32'(resp), 32'(RESP_OKAY));
		write_reg(3, 32'h6, 4'h1);
		check_regs();

		// derived outputs, ntsc stays latched
		for (int t = 0; t < 16; t++) begin
			rand_bits(7, v);
			write_reg(0, v, 4'h1);
			rand_bits(5, v);
			write_reg(1, v, 4'h1);
			rand_bits(4, v);
			write_reg(4, v, 4'h1);
			rand_bits(2, v);
			ovl_i        = v[0];
			cpu_custom_i = v[1];
			@(negedge clk);
			check_derived();
			@(posedge clk);
			#1;
		end

		// user reset picks up the ntsc request
		write_reg(1, exp_reg[1] | 32'h2, 4'h1);
		@(negedge clk);
		check_derived();
		@(posedge clk);
		#1;
		axil_write(`MG_REG_CONTROL, 32'h1, 4'h1, resp);
		axil_read(`MG_REG_CONTROL, rd, resp);
		check_eq("control", rd, 32'h0);
		axil_read(`MG_REG_STATUS, rd, resp);
		check_eq("status", rd, 32'h3);
		release_after_frames(`MG_RESET_FRAMES);
		ntsc_exp = 1'b1;
		check_regs();

		// cpu hold, keyboard reset, cpu core reset
		axil_write(`MG_REG_CONTROL, 32'h2, 4'h1, resp);
		@(negedge clk);
		check_eq("cpu_reset_n_o", 32'(cpu_reset_n_o), 32'd0);
		check_eq("rst_o", 32'(rst_o), 32'd0);
		@(posedge clk);
		#1;
		axil_read(`MG_REG_CONTROL, rd, resp);
		check_eq("control", rd, 32'h2);
		axil_write(`MG_REG_CONTROL, 32'h0, 4'h1, resp);
		@(negedge clk);
		check_eq("cpu_reset_n_o", 32'(cpu_reset_n_o), 32'd1);
		@(posedge clk);
		#1;
		kbdrst_i = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		kbdrst_i = 1'b0;
		release_after_frames(`MG_RESET_FRAMES);
		cpu_reset_n_i = 1'b0;
		@(negedge clk);
		check_eq("rst_o", 32'(rst_o), 32'd1);
		check_eq("cpu_reset_n_o", 32'(cpu_reset_n_o), 32'd1);
		@(posedge clk);
		#1;
		cpu_reset_n_i = 1'b1;
		@(negedge clk);
		check_eq("rst_o", 32'(rst_o), 32'd0);
		check_derived();
		@(posedge clk);
		#1;

		// interrupt levels, checked one cycle later by the checker
		for (int t = 0; t < 40; t++) begin
			rand_bits(9, v);
			irq_i  = v[5:0];
			int7_i = (v[8:6] == 3'd0);
			@(posedge clk);
			#1;
		end

		// power led and vsync toggle
		led_n_i = 1'b0;
		for (int t = 0; t < 24; t++) begin
			rand_bits(1, v);
			hsync_n_i = v[0];
			@(negedge clk);
			check_eq("pwr_led_o", 32'(pwr_led_o), 32'd1);
			@(posedge clk);
			#1;
		end
		led_n_i   = 1'b1;
		hsync_n_i = 1'b1;
		lit       = 0;
		repeat (64) begin
			@(negedge clk);
			if (pwr_led_o)
				lit++;
			@(posedge clk);
			#1;
		end
		if (lit < 3 || lit > 5)
			fail_run($sformatf("power led lit in %0d of 64 hsync-high cycles", lit));
		repeat (5) begin
			vsync_n_i = 1'b0;
			repeat (3) @(posedge clk);
			#1;
			vsync_n_i = 1'b1;
			repeat (5) @(posedge clk);
			#1;
		end

		repeat (4) @(posedge clk);
		if (vs_pend != 0 || vs_flips != 5) begin
			fail_run("vsync_toggle_o flips do not match the vsync falling edges");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/board_status.sv */
// board outputs and indicators
`default_nettype none
`include "minimig_glue_cfg.svh"

module board_status import minimig_glue_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire sys_cfg_t  cfg_i,
	input  wire logic      ovl_i,          // kickstart overlay active
	input  wire logic      cpu_custom_i,   // agnus lets the cpu on chip bus
	input  wire logic      led_n_i,        // cia power led, low is on
	input  wire logic      hsync_n_i,
	input  wire logic      vsync_n_i,
	output logic     [5:0] memcfg_o,
	output logic     [3:0] cpu_config_o,
	output logic           turbochipram_o,
	output logic           turbokick_o,
	output logic           pwr_led_o,
	output logic           vsync_toggle_o  // flips once per frame
);

	logic [`MG_LED_CNT_W-1:0] led_cnt;
	logic                     led_dim;      // counter nonzero, led dark
	logic                     vsync_d;      // last vsync level
	logic                     vsync_t;

	// --------------------------------------------------------------------------
	// exported configuration
	assign memcfg_o     = cfg_i.memory[5:0];
	assign cpu_config_o = cfg_i.cpu;

	// fast chip needs aga, no overlay, cpu bit 2, bus grant and 2MB chip
	assign turbochipram_o = cfg_i.chipset.aga & ~ovl_i & cfg_i.cpu[2] & cpu_custom_i &
		(&cfg_i.memory[1:0]);
	assign turbokick_o = ~ovl_i & cfg_i.cpu[3] & cfg_i.chipset.aga;  // fast kick, aga only

	// --------------------------------------------------------------------------
	// power led, dimmed when off
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt <= '0;
			led_dim <= 1'b0;
		end else if (hsync_n_i) begin
			led_cnt <= led_cnt + 1'b1;
			led_dim <= |led_cnt;            // lit once per counter wrap
		end
	end

	assign pwr_led_o = ~(led_n_i & led_dim);

	// vsync toggle for the host controller
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d <= 1'b1;
			vsync_t <= 1'b0;
		end else begin
			vsync_d <= vsync_n_i;
			if (~vsync_n_i && vsync_d)     // falling edge
				vsync_t <= ~vsync_t;
		end
	end

	assign vsync_toggle_o = vsync_t;

endmodule

`default_nettype wire

/* verilog/cfg_regs.sv */
// configuration register slave
`default_nettype none
`include "minimig_glue_cfg.svh"

module cfg_regs import minimig_glue_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire axil_req_t s_axi_req_i,
	input  wire logic      rst_i,        // combined reset, for status
	input  wire logic      ntsc_i,       // latched video standard
	output axil_rsp_t      s_axi_rsp_o,
	output sys_cfg_t       cfg_o,
	output logic           usrrst_o,     // one clk pulse
	output logic           cpurst_o      // cpu hold level
);

	logic                  wr_acc;       // aw and w taken this cycle
	logic                  wr_en;        // ... and strobe lane 0 set
	logic                  rd_acc;
	logic                  wr_hit;
	logic                  rd_hit;
	logic [`MG_DATA_W-1:0] rd_word;
	sys_cfg_t              cfg_q;
	logic                  usrrst_q;
	logic                  cpurst_q;
	logic                  bvalid_q;
	logic                  rvalid_q;
	axil_resp_e            bresp_q;
	axil_resp_e            rresp_q;
	logic [`MG_DATA_W-1:0] rdata_q;

	// offset is part of the register map
	function automatic logic addr_hit(input logic [`MG_ADDR_W-1:0] addr);
		case (addr)
			`MG_REG_MEMORY, `MG_REG_CHIPSET, `MG_REG_FLOPPY, `MG_REG_IDE,
			`MG_REG_CPU, `MG_REG_CONTROL, `MG_REG_STATUS: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	endfunction

	// --------------------------------------------------------------------------
	// handshakes
	// one write in flight, held off while bvalid waits for bready
	assign wr_acc = s_axi_req_i.awvalid & s_axi_req_i.wvalid & ~bvalid_q;
	assign wr_en  = wr_acc & s_axi_req_i.wstrb[0];
	assign rd_acc = s_axi_req_i.arvalid & ~rvalid_q;
	assign wr_hit = addr_hit(s_axi_req_i.awaddr);
	assign rd_hit = addr_hit(s_axi_req_i.araddr);

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (s_axi_req_i.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (s_axi_req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

	// response payload, captured at acceptance
	always_ff @(posedge clk) begin
		if (wr_acc)
			bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		if (rd_acc) begin
			rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
			rdata_q <= rd_word;
		end
	end

	// --------------------------------------------------------------------------
	// register file
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q    <= '0;
			usrrst_q <= 1'b0;
			cpurst_q <= 1'b0;
		end else begin
			usrrst_q <= 1'b0;                          // self clearing
			if (wr_en) begin
				case (s_axi_req_i.awaddr)
					`MG_REG_MEMORY:  cfg_q.memory  <= s_axi_req_i.wdata[6:0];
					`MG_REG_CHIPSET: cfg_q.chipset <= s_axi_req_i.wdata[4:0];
					`MG_REG_FLOPPY:  cfg_q.floppy  <= s_axi_req_i.wdata[3:0];
					`MG_REG_IDE:     cfg_q.ide     <= s_axi_req_i.wdata[2:0];
					`MG_REG_CPU:     cfg_q.cpu     <= s_axi_req_i.wdata[3:0];
					`MG_REG_CONTROL: begin
						usrrst_q <= s_axi_req_i.wdata[0];
						cpurst_q <= s_axi_req_i.wdata[1];
					end
					default: ;                              // status and holes ignore writes
				endcase
			end
		end
	end

	// read word, zero above each register's width
	always_comb begin
		rd_word = '0;
		case (s_axi_req_i.araddr)
			`MG_REG_MEMORY:  rd_word[6:0] = cfg_q.memory;
			`MG_REG_CHIPSET: rd_word[4:0] = cfg_q.chipset;
			`MG_REG_FLOPPY:  rd_word[3:0] = cfg_q.floppy;
			`MG_REG_IDE:     rd_word[2:0] = cfg_q.ide;
			`MG_REG_CPU:     rd_word[3:0] = cfg_q.cpu;
			`MG_REG_CONTROL: rd_word[1]   = cpurst_q;   // bit 0 reads as zero
			`MG_REG_STATUS:  rd_word[1:0] = {ntsc_i, rst_i};
			default:         rd_word      = '0;
		endcase
	end

	always_comb begin
		s_axi_rsp_o.awready = wr_acc;
		s_axi_rsp_o.wready  = wr_acc;
		s_axi_rsp_o.bresp   = bresp_q;
		s_axi_rsp_o.bvalid  = bvalid_q;
		s_axi_rsp_o.arready = rd_acc;
		s_axi_rsp_o.rdata   = rdata_q;
		s_axi_rsp_o.rresp   = rresp_q;
		s_axi_rsp_o.rvalid  = rvalid_q;
	end

	assign cfg_o    = cfg_q;
	assign usrrst_o = usrrst_q;
	assign cpurst_o = cpurst_q;

endmodule

`default_nettype wire

/* verilog/irq_encoder.sv */
// interrupt priority encoder
`default_nettype none

module irq_encoder (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       rst_i,    // system reset, masks everything
	input  wire logic       int7_i,   // freeze button, nmi
	input  wire logic [5:0] irq_i,    // bit k is level k+1
	output logic      [2:0] ipl_n_o   // m68k _ipl, active low
);

	logic [2:0] level;

	// highest set bit wins, level 7 over all
	always_comb begin
		level = 3'd0;
		for (int k = 0; k < 6; k++) begin
			if (irq_i[k])
				level = 3'(k + 1);
		end
		if (int7_i)
			level = 3'd7;
	end

	// --------------------------------------------------------------------------
	// registered toward the cpu
	always_ff @(posedge clk) begin
		if (reset)
			ipl_n_o <= 3'b111;
		else if (rst_i)
			ipl_n_o <= 3'b111;      // no interrupts during reset
		else
			ipl_n_o <= ~level;
	end

endmodule

`default_nettype wire

/* verilog/minimig_glue.sv */
// minimig board glue top
`default_nettype none

module minimig_glue import minimig_glue_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset,
	// host register port
	input  wire axil_req_t  s_axi_req_i,
	output axil_rsp_t       s_axi_rsp_o,
	// reset sources
	input  wire logic       kbdrst_i,
	input  wire logic       cpu_reset_n_i,
	input  wire logic       sof_i,
	// interrupts
	input  wire logic       int7_i,
	input  wire logic [5:0] irq_i,
	// board inputs
	input  wire logic       ovl_i,
	input  wire logic       cpu_custom_i,
	input  wire logic       led_n_i,
	input  wire logic       hsync_n_i,
	input  wire logic       vsync_n_i,
	// system outputs
	output logic            rst_o,
	output logic            cpu_reset_n_o,
	output logic      [2:0] ipl_n_o,
	output logic            ntsc_o,
	output logic      [5:0] memcfg_o,
	output logic      [3:0] cpu_config_o,
	output logic            turbochipram_o,
	output logic            turbokick_o,
	output logic            pwr_led_o,
	output logic            vsync_toggle_o
);

	sys_cfg_t cfg;      // live user configuration
	logic     usrrst;   // one clk pulse from control reg
	logic     cpurst;   // cpu hold

	// --------------------------------------------------------------------------
	// host side
	cfg_regs u_cfg_regs (
		.clk         (clk),
		.reset       (reset),
		.s_axi_req_i (s_axi_req_i),
		.rst_i       (rst_o),
		.ntsc_i      (ntsc_o),
		.s_axi_rsp_o (s_axi_rsp_o),
		.cfg_o       (cfg),
		.usrrst_o    (usrrst),
		.cpurst_o    (cpurst)
	);

	// resets and cpu interrupts
	reset_seq u_reset_seq (
		.clk           (clk),
		.reset         (reset),
		.kbdrst_i      (kbdrst_i),
		.usrrst_i      (usrrst),
		.cpurst_i      (cpurst),
		.cpu_reset_n_i (cpu_reset_n_i),
		.sof_i         (sof_i),
		.ntsc_req_i    (cfg.chipset.ntsc),
		.rst_o         (rst_o),
		.cpu_reset_n_o (cpu_reset_n_o),
		.ntsc_o        (ntsc_o)
	);

	irq_encoder u_irq_encoder (
		.clk     (clk),
		.reset   (reset),
		.rst_i   (rst_o),
		.int7_i  (int7_i),
		.irq_i   (irq_i),
		.ipl_n_o (ipl_n_o)
	);

	// board outputs
	board_status u_board_status (
		.clk            (clk),
		.reset          (reset),
		.cfg_i          (cfg),
		.ovl_i          (ovl_i),
		.cpu_custom_i   (cpu_custom_i),
		.led_n_i        (led_n_i),
		.hsync_n_i      (hsync_n_i),
		.vsync_n_i      (vsync_n_i),
		.memcfg_o       (memcfg_o),
		.cpu_config_o   (cpu_config_o),
		.turbochipram_o (turbochipram_o),
		.turbokick_o    (turbokick_o),
		.pwr_led_o      (pwr_led_o),
		.vsync_toggle_o (vsync_toggle_o)
	);

endmodule

`default_nettype wire

/* verilog/minimig_glue_cfg.svh */
// minimig glue build constants
`ifndef MINIMIG_GLUE_CFG_SVH
`define MINIMIG_GLUE_CFG_SVH

// --------------------------------------------------------------------------
// host bus
`define MG_ADDR_W 8                // axi4-lite byte address
`define MG_DATA_W 32               // axi4-lite data word

// register map, byte offsets
`define MG_REG_MEMORY  8'h00       // chip/slow ram layout
`define MG_REG_CHIPSET 8'h04       // aga, ecs, a1k, ntsc, turbo
`define MG_REG_FLOPPY  8'h08       // drive count and speed
`define MG_REG_IDE     8'h0C       // gayle and drive enables
`define MG_REG_CPU     8'h10       // cpu type and fast chip/kick
`define MG_REG_CONTROL 8'h14       // user reset, cpu hold
`define MG_REG_STATUS  8'h18       // read only

// --------------------------------------------------------------------------
// board timing
`define MG_RESET_FRAMES 4          // frame starts after last reset source
`define MG_LED_CNT_W    4          // power led pwm counter, 1 in 16 on

`endif

/* verilog/minimig_glue_pkg.sv */
// minimig glue shared types
`default_nettype none
`include "minimig_glue_cfg.svh"

package minimig_glue_pkg;

	// --------------------------------------------------------------------------
	// axi4-lite host port
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10            // unmapped offset
	} axil_resp_e;

	// manager side
	typedef struct packed {
		logic [`MG_ADDR_W-1:0]   awaddr;
		logic                    awvalid;
		logic [`MG_DATA_W-1:0]   wdata;
		logic [`MG_DATA_W/8-1:0] wstrb;   // only bit 0 is looked at
		logic                    wvalid;
		logic                    bready;
		logic [`MG_ADDR_W-1:0]   araddr;
		logic                    arvalid;
		logic                    rready;
	} axil_req_t;

	// subordinate side
	typedef struct packed {
		logic                  awready;
		logic                  wready;
		axil_resp_e            bresp;
		logic                  bvalid;
		logic                  arready;
		logic [`MG_DATA_W-1:0] rdata;
		axil_resp_e            rresp;
		logic                  rvalid;
	} axil_rsp_t;

	// --------------------------------------------------------------------------
	// user configuration
	typedef struct packed {
		logic aga;        // aga chipset, gates the turbo paths
		logic ecs;
		logic a1k;        // a1000 denise id
		logic ntsc;       // requested video standard
		logic turbo_req;  // cpu speed request
	} chipset_cfg_t;

	typedef struct packed {
		logic [6:0]   memory;   // bits 5:0 go to the board
		chipset_cfg_t chipset;
		logic [3:0]   floppy;
		logic [2:0]   ide;      // gayle, master, slave
		logic [3:0]   cpu;      // bit 2 fast chip, bit 3 fast kick
	} sys_cfg_t;

endpackage

`default_nettype wire

/* verilog/reset_seq.sv */
// system reset sequencer
`default_nettype none
`include "minimig_glue_cfg.svh"

module reset_seq (
	input  wire logic clk,
	input  wire logic reset,          // external reset
	input  wire logic kbdrst_i,       // ctrl-amiga-amiga
	input  wire logic usrrst_i,       // host requested
	input  wire logic cpurst_i,       // cpu hold
	input  wire logic cpu_reset_n_i,  // reset seen by the cpu core
	input  wire logic sof_i,          // start of frame pulse
	input  wire logic ntsc_req_i,
	output logic      rst_o,
	output logic      cpu_reset_n_o,
	output logic      ntsc_o
);

	localparam int CNT_W = $clog2(`MG_RESET_FRAMES + 1);

	logic             src_rst;      // any reset source active
	logic [CNT_W-1:0] frame_cnt;    // frame starts left to wait
	logic             sys_reset_q;
	logic             ntsc_q;

	assign src_rst = reset | kbdrst_i | usrrst_i;

	// --------------------------------------------------------------------------
	// hold for a few frames after the last source goes away
	always_ff @(posedge clk) begin
		if (src_rst) begin
			frame_cnt   <= CNT_W'(`MG_RESET_FRAMES);  // reload
			sys_reset_q <= 1'b1;
		end else if (sof_i && frame_cnt != '0) begin
			frame_cnt <= frame_cnt - 1'b1;
			if (frame_cnt == CNT_W'(1))
				sys_reset_q <= 1'b0;                      // last frame start seen
		end
	end

	// video standard only changes while the machine is in reset
	always_ff @(posedge clk) begin
		if (sys_reset_q)
			ntsc_q <= ntsc_req_i;
	end

	// the cpu core can stretch the reset on its own
	assign rst_o         = sys_reset_q | ~cpu_reset_n_i;
	assign cpu_reset_n_o = ~(sys_reset_q | cpurst_i);
	assign ntsc_o        = ntsc_q;

endmodule

`default_nettype wire
